/* Makefile */
SHELL     := /bin/bash

VERILATOR ?= verilator
TOP       ?= tb_tcp_rx_noc_in
RTL_TOP   ?= tcp_rx_noc_in
FILELIST  ?= tcp_rx_noc_in.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= CHECKS FAILED

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	set -o pipefail; ./$(BIN) 2>&1 | tee $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* ctrl_datap_if.sv */
`timescale 1ns/1ns
interface ctrl_datap_if #(
    parameter int data_width = 128
);
    logic store_hdr_flit;
    logic store_meta_flit;
    logic init_num_flits;
    logic decr_num_flits;
    logic last_flit;      // Remaining flit count is one

    // Metadata must fit in one flit, and byte lanes must be a power of two
    if (data_width < tcp_rx_pkg::meta_flit_w || data_width % 8 != 0 ||
        ((data_width / 8) & (data_width / 8 - 1)) != 0) begin : g_width_chk
        $error("ctrl_datap_if: data_width %0d not supported", data_width);
    end

    modport ctrl (
        output store_hdr_flit,
        output store_meta_flit,
        output init_num_flits,
        output decr_num_flits,
        input  last_flit
    );

    modport datap (
        input  store_hdr_flit,
        input  store_meta_flit,
        input  init_num_flits,
        input  decr_num_flits,
        output last_flit
    );

endinterface

/* noc_pkg.sv */
package noc_pkg;

    // Header flit field widths
    localparam int node_w     = 16;
    localparam int msg_type_w = 8;
    localparam int msg_len_w  = 8;    // Also the width of the flit countdown
    localparam int hdr_pad_w  = 16;

    localparam int hdr_flit_w = 2 * node_w + msg_type_w + msg_len_w + hdr_pad_w;

    // Message types seen on the NoC
    typedef enum logic [msg_type_w-1:0] {
        noc_null_msg = 8'h00,
        tcp_rx_msg   = 8'h11,
        tcp_tx_msg   = 8'h12,
        ip_rx_msg    = 8'h21,
        ip_tx_msg    = 8'h22,
        udp_rx_msg   = 8'h31,
        udp_tx_msg   = 8'h32
    } noc_msg_type_e;

    // Low bits of the first flit of every message
    typedef struct packed {
        logic [node_w-1:0]    dst_node;
        logic [node_w-1:0]    src_node;
        noc_msg_type_e        msg_type;
        logic [msg_len_w-1:0] msg_len;    // Flits after the header, metadata included
        logic [hdr_pad_w-1:0] padding;
    } noc_hdr_flit;

endpackage

/* tb_checker.sv */
`timescale 1ns/1ns
module tb_checker #(
    parameter int data_width = 128,
    parameter int n_pkts     = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_val,
    input  logic                    in_rdy,
    input  logic                    hdr_val,
    input  logic                    hdr_rdy,
    input  logic [31:0]             src_ip,
    input  logic [31:0]             dst_ip,
    input  logic [15:0]             tcp_len,
    input  logic                    data_val,
    input  logic                    data_rdy,
    input  logic [data_width-1:0]   data,
    input  logic                    data_last,
    input  logic [$clog2(data_width/8)-1:0] data_padbytes,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [7:0]              paddr,
    input  logic [31:0]             pwdata,
    input  logic [31:0]             prdata,
    input  logic                    pready,
    input  logic                    pslverr,
    input  logic [31:0]             src_tab [n_pkts],
    input  logic [31:0]             dst_tab [n_pkts],
    input  logic [15:0]             len_tab [n_pkts],
    output int                      err_cnt,
    output int                      check_cnt,
    output int                      pkts_seen
);

    localparam int bpf = data_width / 8;

    int          cur;
    int          flit_no;
    int          nflits;
    int          pkt_errs;
    int          rem;
    logic        in_pkt;
    logic        m_busy;      // Model of the FSM being outside rx_hdr
    logic        m_enable;
    logic        exp_err;
    logic        exp_in_rdy;
    logic        exp_hdr_val;
    logic        exp_data_val;
    logic [31:0] m_pkts;
    logic [31:0] m_bytes;
    logic [31:0] exp_rd;

    task automatic compare_val(input string name, input logic [data_width-1:0] exp,
                               input logic [data_width-1:0] got);
        check_cnt++;
        if (exp !== got) begin
            err_cnt++;
            $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic report_fail(input string what);
        err_cnt++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    // Payload byte k of packet pkt, bytes past the TCP length are zero
    function automatic logic [data_width-1:0] exp_flit(input int pkt, input int f, input int len);
        logic [data_width-1:0] v;
        int                    b;
        int                    k;
        v = '0;
        for (b = 0; b < bpf; b++) begin
            k = f * bpf + b;
            if (k < len) v[b*8 +: 8] = 8'(pkt * 37 + k);
        end
        return v;
    endfunction

    // Sampled mid-cycle, where DUT outputs and TB inputs are settled
    always @(negedge clk) begin
        if (rst) begin
            err_cnt   = 0;
            check_cnt = 0;
            pkts_seen = 0;
            cur       = 0;
            in_pkt    = 1'b0;
            m_busy    = 1'b0;
            m_enable  = 1'b0;
            m_pkts    = '0;
            m_bytes   = '0;
        end else begin
            if (psel && penable) begin
                exp_err = 1'b0;
                exp_rd  = '0;
                case (paddr)
                    tcp_rx_pkg::reg_ctrl:     exp_rd[0] = m_enable;
                    tcp_rx_pkg::reg_pkt_cnt:  exp_rd = m_pkts;
                    tcp_rx_pkg::reg_byte_cnt: begin
                        exp_rd  = m_bytes;
                        exp_err = pwrite;    // Read only
                    end
                    tcp_rx_pkg::reg_status: begin
                        exp_rd  = {30'b0, m_enable, m_busy};
                        exp_err = pwrite;
                    end
                    default: exp_err = 1'b1;
                endcase
                compare_val("pready", data_width'(1'b1), data_width'(pready));
                compare_val("pslverr", data_width'(exp_err), data_width'(pslverr));
                if (!pwrite && !exp_err) begin
                    compare_val("prdata", data_width'(exp_rd), data_width'(prdata));
                end
                $display("apb %s 0x%02h done, %0d errors so far",
                         pwrite ? "write" : "read", paddr, err_cnt);
            end
            // Idle, metadata and data phases steer the handshakes differently
            if (!m_busy) begin
                exp_in_rdy   = m_enable;
                exp_hdr_val  = 1'b0;
                exp_data_val = 1'b0;
            end else if (!in_pkt) begin
                exp_in_rdy   = hdr_rdy;
                exp_hdr_val  = in_val;
                exp_data_val = 1'b0;
            end else begin
                exp_in_rdy   = data_rdy;
                exp_hdr_val  = 1'b0;
                exp_data_val = in_val;
            end
            compare_val("in_rdy", data_width'(exp_in_rdy), data_width'(in_rdy));
            compare_val("hdr_val", data_width'(exp_hdr_val), data_width'(hdr_val));
            compare_val("data_val", data_width'(exp_data_val), data_width'(data_val));
            if (in_val && in_rdy && !m_busy) m_busy = 1'b1;    // Header flit taken
            if (hdr_val && hdr_rdy) begin
                if (in_pkt || cur >= n_pkts) begin
                    report_fail("header beat outside an expected packet");
                end else begin
                    pkt_errs = err_cnt;
                    compare_val("src_ip", data_width'(src_tab[cur]), data_width'(src_ip));
                    compare_val("dst_ip", data_width'(dst_tab[cur]), data_width'(dst_ip));
                    compare_val("tcp_len", data_width'(len_tab[cur]), data_width'(tcp_len));
                    in_pkt  = 1'b1;
                    flit_no = 0;
                    nflits  = (int'(len_tab[cur]) + bpf - 1) / bpf;
                end
            end
            if (data_val && data_rdy) begin
                if (!in_pkt) begin
                    report_fail("data beat with no header beat before it");
                end else begin
                    rem = int'(len_tab[cur]) % bpf;
                    compare_val("data", exp_flit(cur, flit_no, int'(len_tab[cur])), data);
                    compare_val("data_last", data_width'(flit_no == nflits - 1),
                                data_width'(data_last));
                    compare_val("data_padbytes",
                                data_width'((flit_no == nflits - 1 && rem != 0) ? bpf - rem : 0),
                                data_width'(data_padbytes));
                    flit_no++;
                    if (flit_no == nflits) begin
                        $display("packet %0d: %0d flits, %0d errors", cur, nflits,
                                 err_cnt - pkt_errs);
                        m_pkts  = m_pkts + 1;
                        m_bytes = m_bytes + 32'(len_tab[cur]);
                        in_pkt  = 1'b0;
                        m_busy  = 1'b0;
                        pkts_seen++;
                        cur++;
                    end
                end
            end
            // Register writes land at the end of the access phase
            if (psel && penable && pwrite && !exp_err) begin
                if (paddr == tcp_rx_pkg::reg_ctrl) m_enable = pwdata[0];
                if (paddr == tcp_rx_pkg::reg_pkt_cnt) begin
                    m_pkts  = '0;
                    m_bytes = '0;
                end
            end
        end
    end

endmodule

/* tb_tcp_rx_noc_in.sv */
`timescale 1ns/1ns
module tb_tcp_rx_noc_in;

    localparam int data_width     = 128;
    localparam int bpf            = data_width / 8;
    localparam int padbytes_w     = $clog2(bpf);
    localparam int n_pkts         = 8;
    localparam int clk_period     = 8;
    localparam int timeout_cycles = 200 * n_pkts + 500;

    logic                  clk;
    logic                  rst;
    logic                  in_val;
    logic [data_width-1:0] in_data;
    logic                  in_rdy;
    logic                  hdr_val;
    logic                  hdr_rdy;
    logic [31:0]           src_ip;
    logic [31:0]           dst_ip;
    logic [15:0]           tcp_len;
    logic                  data_val;
    logic                  data_rdy;
    logic [data_width-1:0] data;
    logic                  data_last;
    logic [padbytes_w-1:0] data_padbytes;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [7:0]            paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;

    // Packet table, also read by the checker
    logic [31:0]           src_tab [n_pkts];
    logic [31:0]           dst_tab [n_pkts];
    logic [15:0]           len_tab [n_pkts];

    int                    err_cnt;
    int                    check_cnt;
    int                    pkts_seen;

    tcp_rx_noc_in #(.data_width(data_width)) uut (
        .clk(clk), .rst(rst),
        .in_val(in_val), .in_data(in_data), .in_rdy(in_rdy),
        .hdr_val(hdr_val), .hdr_rdy(hdr_rdy),
        .src_ip(src_ip), .dst_ip(dst_ip), .tcp_len(tcp_len),
        .data_val(data_val), .data_rdy(data_rdy), .data(data),
        .data_last(data_last), .data_padbytes(data_padbytes),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    tb_checker #(.data_width(data_width), .n_pkts(n_pkts)) chk (
        .clk(clk), .rst(rst),
        .in_val(in_val), .in_rdy(in_rdy),
        .hdr_val(hdr_val), .hdr_rdy(hdr_rdy),
        .src_ip(src_ip), .dst_ip(dst_ip), .tcp_len(tcp_len),
        .data_val(data_val), .data_rdy(data_rdy), .data(data),
        .data_last(data_last), .data_padbytes(data_padbytes),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .src_tab(src_tab), .dst_tab(dst_tab), .len_tab(len_tab),
        .err_cnt(err_cnt), .check_cnt(check_cnt), .pkts_seen(pkts_seen)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the run was still going after %0d cycles", timeout_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Holds the flit until the cycle where in_rdy is seen high
    task automatic drive_flit(input logic [data_width-1:0] flit);
        logic took;
        in_val  = 1'b1;
        in_data = flit;
        took    = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = in_rdy;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_packet(input int i);
        noc_pkg::noc_hdr_flit    hdr;
        tcp_rx_pkg::ip_meta_flit meta;
        logic [data_width-1:0]   flit;
        int                      nflits;
        int                      f;
        int                      b;
        int                      k;
        nflits       = (int'(len_tab[i]) + bpf - 1) / bpf;
        hdr.dst_node = 16'h0003;
        hdr.src_node = 16'(i);
        hdr.msg_type = noc_pkg::tcp_rx_msg;
        hdr.msg_len  = 8'(nflits + 1);    // Data flits plus metadata
        hdr.padding  = '0;
        flit = '0;
        flit[noc_pkg::hdr_flit_w-1:0] = hdr;
        drive_flit(flit);
        meta.src_ip      = src_tab[i];
        meta.dst_ip      = dst_tab[i];
        meta.payload_len = len_tab[i];
        flit = '0;
        flit[tcp_rx_pkg::meta_flit_w-1:0] = meta;
        drive_flit(flit);
        for (f = 0; f < nflits; f++) begin
            flit = '0;
            for (b = 0; b < bpf; b++) begin
                k = f * bpf + b;
                if (k < int'(len_tab[i])) flit[b*8 +: 8] = 8'(i * 37 + k);
            end
            drive_flit(flit);
        end
        in_val  = 1'b0;
        in_data = '0;
    endtask

    task automatic stall_ready();
        forever begin
            hdr_rdy  = ($urandom % 4) != 0;
            data_rdy = ($urandom % 4) != 0;
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        void'($urandom(32'hc40a_5a76));
        src_tab = '{32'h0a00_0001, 32'h0a00_0102, 32'hc0a8_0003, 32'hac10_2004,
                    32'h0a0b_0c0d, 32'hc0a8_ff01, 32'h7f00_0001, 32'h0102_0304};
        dst_tab = '{32'h0a00_00fe, 32'h0a00_01fe, 32'hc0a8_00fe, 32'hac10_20fe,
                    32'h0d0c_0b0a, 32'hc0a8_ff02, 32'h7f00_0002, 32'h0403_0201};
        len_tab = '{16'd1, 16'd15, 16'd16, 16'd17, 16'd40, 16'd64, 16'd100, 16'd7};
        rst     = 1'b1;
        in_val  = 1'b0;
        in_data = '0;
        hdr_rdy = 1'b0;
        data_rdy = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        fork
            stall_ready();
        join_none
        apb_access(1'b0, tcp_rx_pkg::reg_ctrl, '0);
        for (int i = 0; i < n_pkts; i++) begin
            if (i == 4) apb_access(1'b1, tcp_rx_pkg::reg_ctrl, 32'd0);
            if (i == 0 || i == 4) begin
                // Header waits at the input until enable is written
                fork
                    send_packet(i);
                    begin
                        repeat (20) @(posedge clk);
                        #1 apb_access(1'b1, tcp_rx_pkg::reg_ctrl, 32'd1);
                    end
                join
            end else begin
                send_packet(i);
            end
        end
        repeat (4) @(posedge clk);    // Counters trail the last flit by two edges
        #1 apb_access(1'b0, tcp_rx_pkg::reg_pkt_cnt, '0);
        apb_access(1'b0, tcp_rx_pkg::reg_byte_cnt, '0);
        apb_access(1'b0, tcp_rx_pkg::reg_status, '0);
        apb_access(1'b1, tcp_rx_pkg::reg_pkt_cnt, 32'hffff_ffff);
        apb_access(1'b0, tcp_rx_pkg::reg_pkt_cnt, '0);
        apb_access(1'b0, tcp_rx_pkg::reg_byte_cnt, '0);
        apb_access(1'b0, 8'h10, '0);
        apb_access(1'b1, tcp_rx_pkg::reg_byte_cnt, 32'd1);
        repeat (2) @(posedge clk);
        if (pkts_seen != n_pkts) begin
            $display("Error: %0d of %0d packets came out complete", pkts_seen, n_pkts);
        end
        $display("%0d checks, %0d errors, %0d of %0d packets", check_cnt, err_cnt,
                 pkts_seen, n_pkts);
        if (err_cnt != 0 || pkts_seen != n_pkts) begin
            $display("CHECKS FAILED");
        end else begin
            $display("ALL CHECKS PASSED");
        end
        $finish;
    end

endmodule

/* tcp_rx_noc_in.f */
noc_pkg.sv
tcp_rx_pkg.sv
ctrl_datap_if.sv
tcp_rx_noc_in_datap.sv
tcp_rx_noc_in_ctrl.sv
tcp_rx_noc_in_regs.sv
tcp_rx_noc_in.sv
tb_checker.sv
tb_tcp_rx_noc_in.sv

/* tcp_rx_noc_in.sv */
`timescale 1ns/1ns
module tcp_rx_noc_in #(
    parameter int  data_width = 128,
    localparam int padbytes_w = $clog2(data_width / 8)
) (
    input  logic                              clk,
    input  logic                              rst,

    // NoC input stream
    input  logic                              in_val,
    input  logic [data_width-1:0]             in_data,
    output logic                              in_rdy,

    // Header beat
    output logic                              hdr_val,
    input  logic                              hdr_rdy,
    output logic [tcp_rx_pkg::ip_addr_w-1:0]  src_ip,
    output logic [tcp_rx_pkg::ip_addr_w-1:0]  dst_ip,
    output logic [tcp_rx_pkg::tot_len_w-1:0]  tcp_len,

    // Payload stream
    output logic                              data_val,
    input  logic                              data_rdy,
    output logic [data_width-1:0]             data,
    output logic                              data_last,
    output logic [padbytes_w-1:0]             data_padbytes,

    // APB config
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [tcp_rx_pkg::apb_addr_w-1:0] paddr,
    input  logic [tcp_rx_pkg::apb_data_w-1:0] pwdata,
    output logic [tcp_rx_pkg::apb_data_w-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr
);

    logic                             enable;
    logic                             busy;
    logic                             pkt_done;
    logic [tcp_rx_pkg::tot_len_w-1:0] pkt_bytes;

    ctrl_datap_if #(.data_width(data_width)) cd ();

    tcp_rx_noc_in_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .in_val    (in_val),
        .in_rdy    (in_rdy),
        .hdr_val   (hdr_val),
        .hdr_rdy   (hdr_rdy),
        .data_val  (data_val),
        .data_rdy  (data_rdy),
        .enable    (enable),
        .tcp_len   (tcp_len),
        .cd        (cd.ctrl),
        .pkt_done  (pkt_done),
        .pkt_bytes (pkt_bytes),
        .busy      (busy)
    );

    tcp_rx_noc_in_datap #(.data_width(data_width)) u_datap (
        .clk           (clk),
        .rst           (rst),
        .in_data       (in_data),
        .cd            (cd.datap),
        .src_ip        (src_ip),
        .dst_ip        (dst_ip),
        .tcp_len       (tcp_len),
        .data          (data),
        .data_last     (data_last),
        .data_padbytes (data_padbytes)
    );

    tcp_rx_noc_in_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .enable    (enable),
        .busy      (busy),
        .pkt_done  (pkt_done),
        .pkt_bytes (pkt_bytes)
    );

endmodule

/* tcp_rx_noc_in_ctrl.sv */
`timescale 1ns/1ns
module tcp_rx_noc_in_ctrl (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            in_val,
    output logic                            in_rdy,

    output logic                            hdr_val,
    input  logic                            hdr_rdy,

    output logic                            data_val,
    input  logic                            data_rdy,

    input  logic                            enable,
    input  logic [tcp_rx_pkg::tot_len_w-1:0] tcp_len,

    ctrl_datap_if.ctrl                      cd,

    output logic                            pkt_done,
    output logic [tcp_rx_pkg::tot_len_w-1:0] pkt_bytes,
    output logic                            busy
);

    tcp_rx_pkg::rx_state_e state;
    tcp_rx_pkg::rx_state_e state_next;
    logic                  pkt_end;

    always_comb begin
        state_next         = state;
        in_rdy             = 1'b0;
        hdr_val            = 1'b0;
        data_val           = 1'b0;
        cd.store_hdr_flit  = 1'b0;
        cd.store_meta_flit = 1'b0;
        cd.init_num_flits  = 1'b0;
        cd.decr_num_flits  = 1'b0;
        pkt_end            = 1'b0;

        case (state)
            tcp_rx_pkg::rx_hdr: begin
                in_rdy = enable;    // Only new packets are held off
                if (in_val && enable) begin
                    cd.store_hdr_flit = 1'b1;
                    cd.init_num_flits = 1'b1;
                    state_next        = tcp_rx_pkg::rx_meta;
                end
            end
            tcp_rx_pkg::rx_meta: begin
                // Metadata flit goes straight out as the header beat
                hdr_val = in_val;
                in_rdy  = hdr_rdy;
                if (in_val && hdr_rdy) begin
                    cd.store_meta_flit = 1'b1;
                    cd.decr_num_flits  = 1'b1;
                    state_next         = tcp_rx_pkg::rx_data;
                end
            end
            tcp_rx_pkg::rx_data: begin
                data_val = in_val;
                in_rdy   = data_rdy;
                if (in_val && data_rdy) begin
                    cd.decr_num_flits = 1'b1;
                    if (cd.last_flit) begin
                        pkt_end    = 1'b1;
                        state_next = tcp_rx_pkg::rx_hdr;
                    end
                end
            end
            default: begin
                state_next = tcp_rx_pkg::rx_hdr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= tcp_rx_pkg::rx_hdr;
            pkt_done <= 1'b0;
        end else begin
            state    <= state_next;
            pkt_done <= pkt_end;
        end
    end

    always_ff @(posedge clk) begin
        if (cd.store_meta_flit) begin
            pkt_bytes <= tcp_len;    // Held until the next metadata flit
        end
    end

    assign busy = (state != tcp_rx_pkg::rx_hdr);

    last_not_in_hdr: assert property (@(posedge clk) disable iff (rst)
        state == tcp_rx_pkg::rx_hdr |-> !cd.last_flit);

    // Count equals msg_len here, so msg_len of 2 or more leaves last_flit low
    hdr_len_min: assert property (@(posedge clk) disable iff (rst)
        state == tcp_rx_pkg::rx_meta |-> !cd.last_flit);

    no_accept_disabled: assert property (@(posedge clk) disable iff (rst)
        (state == tcp_rx_pkg::rx_hdr && !enable) |=> state == tcp_rx_pkg::rx_hdr);

endmodule

/* tcp_rx_noc_in_datap.sv */
`timescale 1ns/1ns
module tcp_rx_noc_in_datap #(
    parameter int  data_width     = 128,
    localparam int bytes_per_flit = data_width / 8,
    localparam int padbytes_w     = $clog2(bytes_per_flit)
) (
    input  logic                            clk,
    input  logic                            rst,

    input  logic [data_width-1:0]           in_data,

    ctrl_datap_if.datap                     cd,

    output logic [tcp_rx_pkg::ip_addr_w-1:0] src_ip,
    output logic [tcp_rx_pkg::ip_addr_w-1:0] dst_ip,
    output logic [tcp_rx_pkg::tot_len_w-1:0] tcp_len,

    output logic [data_width-1:0]           data,
    output logic                            data_last,
    output logic [padbytes_w-1:0]           data_padbytes
);

    noc_pkg::noc_hdr_flit          hdr_in;
    noc_pkg::noc_hdr_flit          hdr_reg;
    noc_pkg::noc_hdr_flit          hdr_next;

    tcp_rx_pkg::ip_meta_flit       meta_in;
    tcp_rx_pkg::ip_meta_flit       meta_reg;
    tcp_rx_pkg::ip_meta_flit       meta_next;

    logic [noc_pkg::msg_len_w-1:0] flits_left;
    logic [padbytes_w-1:0]         len_rem;
    logic [padbytes_w:0]           pad_calc;

    assign hdr_in  = in_data[noc_pkg::hdr_flit_w-1:0];
    assign meta_in = in_data[tcp_rx_pkg::meta_flit_w-1:0];

    assign hdr_next  = cd.store_hdr_flit  ? hdr_in  : hdr_reg;
    assign meta_next = cd.store_meta_flit ? meta_in : meta_reg;

    // Header beat fields are valid while the metadata flit is on the input
    assign src_ip  = meta_next.src_ip;
    assign dst_ip  = meta_next.dst_ip;
    assign tcp_len = meta_next.payload_len;

    assign cd.last_flit = (flits_left == 1);

    assign data      = in_data;       // No added latency on the data path
    assign data_last = cd.last_flit;

    // Unused bytes in the final flit
    assign len_rem  = meta_reg.payload_len[padbytes_w-1:0];
    assign pad_calc = (len_rem == '0) ? '0
                                      : (padbytes_w + 1)'(bytes_per_flit) - {1'b0, len_rem};

    assign data_padbytes = cd.last_flit ? pad_calc[padbytes_w-1:0] : '0;

    always_ff @(posedge clk) begin
        hdr_reg  <= hdr_next;
        meta_reg <= meta_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flits_left <= '0;
        end else if (cd.init_num_flits) begin
            flits_left <= hdr_next.msg_len;
        end else if (cd.decr_num_flits) begin
            flits_left <= flits_left - 1'b1;
        end
    end

    // Control must not count past the end of the message
    count_no_underflow: assert property (@(posedge clk) disable iff (rst)
        cd.decr_num_flits |-> flits_left != '0);

endmodule

/* tcp_rx_noc_in_regs.sv */
`timescale 1ns/1ns
module tcp_rx_noc_in_regs (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [tcp_rx_pkg::apb_addr_w-1:0] paddr,
    input  logic [tcp_rx_pkg::apb_data_w-1:0] pwdata,
    output logic [tcp_rx_pkg::apb_data_w-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr,

    output logic                              enable,
    input  logic                              busy,
    input  logic                              pkt_done,
    input  logic [tcp_rx_pkg::tot_len_w-1:0]  pkt_bytes
);

    logic [tcp_rx_pkg::cnt_w-1:0]      pkt_cnt;
    logic [tcp_rx_pkg::cnt_w-1:0]      byte_cnt;
    logic [tcp_rx_pkg::apb_data_w-1:0] rd_mux;
    logic                              addr_err;
    logic                              err_q;
    logic                              setup;
    logic                              access;
    logic                              wr_en;

    assign setup   = psel && !penable;
    assign access  = psel && penable;
    assign wr_en   = access && pwrite && !err_q;
    assign pready  = 1'b1;
    assign pslverr = access && err_q;

    // Read mux and error decode
    always_comb begin
        rd_mux   = '0;
        addr_err = 1'b0;
        case (tcp_rx_pkg::reg_addr_e'(paddr))
            tcp_rx_pkg::reg_ctrl:     rd_mux[tcp_rx_pkg::ctrl_enable_bit] = enable;
            tcp_rx_pkg::reg_pkt_cnt:  rd_mux = pkt_cnt;
            tcp_rx_pkg::reg_byte_cnt: begin
                rd_mux   = byte_cnt;
                addr_err = pwrite;    // Read only
            end
            tcp_rx_pkg::reg_status: begin
                rd_mux[tcp_rx_pkg::stat_busy_bit]   = busy;
                rd_mux[tcp_rx_pkg::stat_enable_bit] = enable;
                addr_err = pwrite;
            end
            default: addr_err = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prdata <= '0;
            err_q  <= 1'b0;
        end else if (setup) begin
            prdata <= pwrite ? '0 : rd_mux;
            err_q  <= addr_err;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable   <= 1'b0;
            pkt_cnt  <= '0;
            byte_cnt <= '0;
        end else begin
            if (wr_en && paddr == tcp_rx_pkg::reg_ctrl) begin
                enable <= pwdata[tcp_rx_pkg::ctrl_enable_bit];
            end
            if (wr_en && paddr == tcp_rx_pkg::reg_pkt_cnt) begin
                pkt_cnt  <= '0;    // Clear wins over a same-cycle count
                byte_cnt <= '0;
            end else if (pkt_done) begin
                pkt_cnt  <= pkt_cnt + 1'b1;
                byte_cnt <= byte_cnt + tcp_rx_pkg::cnt_w'(pkt_bytes);
            end
        end
    end

    prdata_hold: assert property (@(posedge clk) disable iff (rst)
        access |=> $stable(prdata));

endmodule

/* tcp_rx_pkg.sv */
package tcp_rx_pkg;

    // IP field widths, fixed by the protocol
    localparam int ip_addr_w   = 32;
    localparam int tot_len_w   = 16;
    localparam int meta_flit_w = 2 * ip_addr_w + tot_len_w;

    // Metadata flit, low bits of the second flit, rest is zero
    typedef struct packed {
        logic [ip_addr_w-1:0] src_ip;
        logic [ip_addr_w-1:0] dst_ip;
        logic [tot_len_w-1:0] payload_len;    // TCP length in bytes
    } ip_meta_flit;

    typedef enum logic [1:0] {
        rx_hdr  = 2'd0,
        rx_meta = 2'd1,
        rx_data = 2'd2
    } rx_state_e;

    // APB side
    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;
    localparam int cnt_w      = 32;

    typedef enum logic [apb_addr_w-1:0] {
        reg_ctrl     = 8'h00,
        reg_pkt_cnt  = 8'h04,    // Any write clears both counters
        reg_byte_cnt = 8'h08,
        reg_status   = 8'h0C
    } reg_addr_e;

    // Bit positions
    localparam int ctrl_enable_bit = 0;
    localparam int stat_busy_bit   = 0;
    localparam int stat_enable_bit = 1;

endpackage
